/* common/adder_issue_macros.svh */
// sizing for the adder issue path; PREG_NUM and ISSUE_DEPTH must be powers of two
`ifndef ADDER_ISSUE_MACROS_SVH
`define ADDER_ISSUE_MACROS_SVH

// issue queue slots
`define ISSUE_DEPTH 4

// physical registers, register 0 is hardwired to zero
`define PREG_NUM 32

// wishbone byte address width
// five bits cover the map up to PRF_HI at 0x10
`define WB_ADR_W 5

`endif

/* common/issue_pkg.sv */
// types for the adder issue path; widths follow adder_issue_macros.svh, xlen fixed at 64
`include "adder_issue_macros.svh"

package issue_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [$clog2(`PREG_NUM)-1:0] preg_idx_t;
	typedef logic [$clog2(`ISSUE_DEPTH)-1:0] slot_idx_t;

	// the eight instructions the adder handles
	typedef enum logic [2:0] {
		op_lui,
		op_auipc,
		op_addi,
		op_addiw,
		op_add,
		op_addw,
		op_sub,
		op_subw
	} adder_op_e;

	// renamed instruction as it leaves dispatch
	typedef struct packed {
		adder_op_e op;
		xlen_t     pc;
		xlen_t     imm;
		preg_idx_t rd;
		preg_idx_t rs1;
		preg_idx_t rs2;
	} issue_info_t;

	// operands already resolved at issue
	typedef struct packed {
		logic      fun_sub;
		logic      is32;
		preg_idx_t rd;
		xlen_t     op1;
		xlen_t     op2;
	} exec_info_t;

	typedef struct packed {
		logic      valid;
		preg_idx_t rd;
		xlen_t     data;
	} wb_result_t;

	// register file preload from the config port
	typedef struct packed {
		logic      valid;
		preg_idx_t idx;
		xlen_t     data;
	} prf_wr_t;

endpackage

/* adder_issue/issue_buffer.sv */
// unordered issue slots; push is dropped if no slot is free, pop_index must point at a valid slot
`timescale 1ns/10ps

module issue_buffer #(
	parameter int DP = 4
) (
	input  logic                                CLK,
	input  logic                                rst_n,

	input  logic                                push,
	input  issue_pkg::issue_info_t              push_info,
	output logic                                full,

	input  logic                                pop,
	input  issue_pkg::slot_idx_t                pop_index,
	output issue_pkg::issue_info_t [DP-1:0]     info_q,
	output logic [DP-1:0]                       valid_q
);

	logic [DP-1:0] valid_r;
	issue_pkg::issue_info_t [DP-1:0] info_r;
	logic [DP-1:0] free;
	logic [DP-1:0] push_sel;
	logic found;

	// a slot popped this cycle counts as free
	always_comb begin
		free = ~valid_r;
		if (pop)
			free[pop_index] = 1'b1;
	end

	// lowest free slot takes the push
	always_comb begin
		push_sel = '0;
		found = 1'b0;
		for (int i = 0; i < DP; i++) begin
			if (free[i] && !found) begin
				push_sel[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			valid_r <= '0;
		end else begin
			for (int i = 0; i < DP; i++) begin
				if (pop && pop_index == issue_pkg::slot_idx_t'(i))
					valid_r[i] <= 1'b0;
				if (push && push_sel[i])
					valid_r[i] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		for (int i = 0; i < DP; i++) begin
			if (push && push_sel[i])
				info_r[i] <= push_info;
		end
	end

	assign full = &valid_r;
	assign info_q = info_r;
	assign valid_q = valid_r;

endmodule

/* adder_issue/lzc.sv */
// combinational first-set picker from bit 0 upward; cnt_o is 0 when empty_o is high
`timescale 1ns/10ps

module lzc #(
	parameter int WIDTH = 4,
	localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
	input  logic [WIDTH-1:0] in_i,
	output logic [CNT_W-1:0] cnt_o,
	output logic             empty_o
);

	// scan downward so the lowest set bit wins
	always_comb begin
		cnt_o = '0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (in_i[i])
				cnt_o = CNT_W'(i);
		end
	end

	assign empty_o = ~|in_i;

endmodule

/* adder_issue/adder_issue.sv */
// adder issue queue; no bypass, selection by slot position only, execute side is always ready
`timescale 1ns/10ps
`include "adder_issue_macros.svh"

module adder_issue (
	input  logic                                        CLK,
	input  logic                                        rst_n,

	input  logic                                        dispatch_valid,
	output logic                                        dispatch_ready,
	input  issue_pkg::issue_info_t                      dispatch_info,

	input  logic                                        issue_en,

	input  logic [`PREG_NUM-1:0]                        src_ready,
	input  issue_pkg::xlen_t [`PREG_NUM-1:0]            prf_value,

	output logic                                        exec_valid,
	output issue_pkg::exec_info_t                       exec_info
);

	localparam int DEPTH = `ISSUE_DEPTH;

	logic buf_full;
	logic buf_push;
	logic buf_pop;
	issue_pkg::slot_idx_t pop_index;
	issue_pkg::issue_info_t [DEPTH-1:0] info_q;
	logic [DEPTH-1:0] valid_q;

	logic [DEPTH-1:0] need_rs1;
	logic [DEPTH-1:0] need_rs2;
	logic [DEPTH-1:0] fun_sub;
	logic [DEPTH-1:0] is32;
	logic [DEPTH-1:0] raw_clear;
	issue_pkg::xlen_t [DEPTH-1:0] src1;
	issue_pkg::xlen_t [DEPTH-1:0] src2;
	issue_pkg::xlen_t [DEPTH-1:0] op1;
	issue_pkg::xlen_t [DEPTH-1:0] op2;
	logic none_clear;

	issue_buffer #(
		.DP(DEPTH)
	) u_buffer (
		.CLK(CLK),
		.rst_n(rst_n),
		.push(buf_push),
		.push_info(dispatch_info),
		.full(buf_full),
		.pop(buf_pop),
		.pop_index(pop_index),
		.info_q(info_q),
		.valid_q(valid_q)
	);

	// per slot decode, source readiness and operands
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			src1[i] = prf_value[info_q[i].rs1];
			src2[i] = prf_value[info_q[i].rs2];
			need_rs1[i] = 1'b1;
			need_rs2[i] = 1'b0;
			op1[i] = src1[i];
			op2[i] = info_q[i].imm;
			case (info_q[i].op)
				issue_pkg::op_lui: begin
					need_rs1[i] = 1'b0;
					op1[i] = '0;
				end
				issue_pkg::op_auipc: begin
					need_rs1[i] = 1'b0;
					op1[i] = info_q[i].pc;
				end
				issue_pkg::op_addi, issue_pkg::op_addiw: begin
				end
				default: begin
					need_rs2[i] = 1'b1;
					op2[i] = src2[i];
				end
			endcase
			fun_sub[i] = (info_q[i].op == issue_pkg::op_sub) ||
			             (info_q[i].op == issue_pkg::op_subw);
			is32[i] = (info_q[i].op == issue_pkg::op_addiw) ||
			          (info_q[i].op == issue_pkg::op_addw) ||
			          (info_q[i].op == issue_pkg::op_subw);
			raw_clear[i] = valid_q[i] &&
			               (!need_rs1[i] || src_ready[info_q[i].rs1]) &&
			               (!need_rs2[i] || src_ready[info_q[i].rs2]);
		end
	end

	lzc #(
		.WIDTH(DEPTH)
	) u_select (
		.in_i(raw_clear),
		.cnt_o(pop_index),
		.empty_o(none_clear)
	);

	assign exec_valid = issue_en && !none_clear;

	always_comb begin
		exec_info.fun_sub = fun_sub[pop_index];
		exec_info.is32 = is32[pop_index];
		exec_info.rd = info_q[pop_index].rd;
		exec_info.op1 = op1[pop_index];
		exec_info.op2 = op2[pop_index];
	end

	// adder never stalls, so every valid issue pops
	assign buf_pop = exec_valid;

	// room exists if not full or a slot frees this cycle
	assign dispatch_ready = !buf_full || buf_pop;
	assign buf_push = dispatch_valid && dispatch_ready;

endmodule

/* adder_issue/adder_exec.sv */
// single stage 64-bit adder; W forms sign extend bit 31, results to rd 0 are dropped
`timescale 1ns/10ps

module adder_exec (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  exec_valid,
	input  issue_pkg::exec_info_t exec_info,
	output issue_pkg::wb_result_t result
);

	issue_pkg::xlen_t sum;
	issue_pkg::xlen_t res;

	logic valid_r;
	issue_pkg::preg_idx_t rd_r;
	issue_pkg::xlen_t data_r;

	always_comb begin
		if (exec_info.fun_sub)
			sum = exec_info.op1 - exec_info.op2;
		else
			sum = exec_info.op1 + exec_info.op2;
		// word ops keep the low half only
		if (exec_info.is32)
			res = {{32{sum[31]}}, sum[31:0]};
		else
			res = sum;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n)
			valid_r <= 1'b0;
		else
			valid_r <= exec_valid && (exec_info.rd != '0);
	end

	always_ff @(posedge CLK) begin
		if (exec_valid) begin
			rd_r <= exec_info.rd;
			data_r <= res;
		end
	end

	assign result = '{valid: valid_r, rd: rd_r, data: data_r};

endmodule

/* hw/phy_regfile.sv */
// flop based register file with scoreboard; allocation wins over writeback on the same register
`timescale 1ns/10ps
`include "adder_issue_macros.svh"

module phy_regfile (
	input  logic                                CLK,
	input  logic                                rst_n,

	input  issue_pkg::wb_result_t               wb,

	input  logic                                alloc_valid,
	input  issue_pkg::preg_idx_t                alloc_rd,

	input  issue_pkg::prf_wr_t                  preload,

	output issue_pkg::xlen_t [`PREG_NUM-1:0]    value,
	output logic [`PREG_NUM-1:0]                ready
);

	issue_pkg::xlen_t [`PREG_NUM-1:0] value_r;
	logic [`PREG_NUM-1:0] ready_r;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			value_r <= '0;
			ready_r <= '1;
		end else begin
			// register 0 is never touched after reset
			for (int i = 1; i < `PREG_NUM; i++) begin
				if (preload.valid && preload.idx == issue_pkg::preg_idx_t'(i)) begin
					value_r[i] <= preload.data;
					ready_r[i] <= 1'b1;
				end
				if (wb.valid && wb.rd == issue_pkg::preg_idx_t'(i)) begin
					value_r[i] <= wb.data;
					ready_r[i] <= 1'b1;
				end
				// newly dispatched producer
				if (alloc_valid && alloc_rd == issue_pkg::preg_idx_t'(i))
					ready_r[i] <= 1'b0;
			end
		end
	end

	assign value = value_r;
	assign ready = ready_r;

endmodule

/* hw/issue_csr.sv */
// wishbone classic slave, 32-bit data, one wait state per access; PRF_HI must be written before PRF_LO
`timescale 1ns/10ps
`include "adder_issue_macros.svh"

module issue_csr (
	input  logic                                CLK,
	input  logic                                rst_n,

	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic [`WB_ADR_W-1:0]                wb_adr,
	input  logic [31:0]                         wb_dat_w,
	output logic [31:0]                         wb_dat_r,
	output logic                                wb_ack,

	input  logic                                issue_fire,
	input  issue_pkg::xlen_t [`PREG_NUM-1:0]    prf_value,
	output logic                                issue_en,
	output issue_pkg::prf_wr_t                  preload
);

	localparam logic [`WB_ADR_W-1:0] adr_ctrl = `WB_ADR_W'h00;
	localparam logic [`WB_ADR_W-1:0] adr_issued = `WB_ADR_W'h04;
	localparam logic [`WB_ADR_W-1:0] adr_prf_sel = `WB_ADR_W'h08;
	localparam logic [`WB_ADR_W-1:0] adr_prf_lo = `WB_ADR_W'h0c;
	localparam logic [`WB_ADR_W-1:0] adr_prf_hi = `WB_ADR_W'h10;

	logic ack_r;
	logic access;
	logic wr_en;
	logic ctrl_en;
	logic [31:0] issued_cnt;
	issue_pkg::preg_idx_t prf_sel;
	logic [31:0] hi_hold;
	issue_pkg::xlen_t sel_value;
	logic [31:0] rdata;

	// act once per request, on the edge that raises ack
	assign access = wb_cyc && wb_stb && !ack_r;
	assign wr_en = access && wb_we;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ack_r <= 1'b0;
			ctrl_en <= 1'b0;
			issued_cnt <= '0;
			prf_sel <= '0;
		end else begin
			ack_r <= access;
			if (issue_fire)
				issued_cnt <= issued_cnt + 32'd1;
			if (wr_en && wb_adr == adr_ctrl)
				ctrl_en <= wb_dat_w[0];
			if (wr_en && wb_adr == adr_prf_sel)
				prf_sel <= wb_dat_w[$bits(prf_sel)-1:0];
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en && wb_adr == adr_prf_hi)
			hi_hold <= wb_dat_w;
		if (access)
			wb_dat_r <= rdata;
	end

	assign sel_value = prf_value[prf_sel];

	always_comb begin
		case (wb_adr)
			adr_ctrl:    rdata = {31'd0, ctrl_en};
			adr_issued:  rdata = issued_cnt;
			adr_prf_sel: rdata = 32'(prf_sel);
			adr_prf_lo:  rdata = sel_value[31:0];
			adr_prf_hi:  rdata = sel_value[63:32];
			default:     rdata = '0;
		endcase
	end

	// low word write commits the full register
	assign preload = '{
		valid: wr_en && (wb_adr == adr_prf_lo),
		idx: prf_sel,
		data: {hi_hold, wb_dat_w}
	};

	assign wb_ack = ack_r;
	assign issue_en = ctrl_en;

endmodule

/* hw/adder_issue_top.sv */
// adder issue subsystem; issue stays off until CTRL bit 0 is set over wishbone
`timescale 1ns/10ps
`include "adder_issue_macros.svh"

module adder_issue_top (
	input  logic                    CLK,
	input  logic                    rst_n,

	input  logic                    dispatch_valid,
	output logic                    dispatch_ready,
	input  issue_pkg::issue_info_t  dispatch_info,

	output issue_pkg::wb_result_t   result,

	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`WB_ADR_W-1:0]    wb_adr,
	input  logic [31:0]             wb_dat_w,
	output logic [31:0]             wb_dat_r,
	output logic                    wb_ack
);

	logic issue_en;
	logic exec_valid;
	issue_pkg::exec_info_t exec_info;
	logic [`PREG_NUM-1:0] src_ready;
	issue_pkg::xlen_t [`PREG_NUM-1:0] prf_value;
	issue_pkg::prf_wr_t preload;
	logic dispatch_fire;

	assign dispatch_fire = dispatch_valid && dispatch_ready;

	adder_issue u_issue (
		.CLK(CLK),
		.rst_n(rst_n),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready),
		.dispatch_info(dispatch_info),
		.issue_en(issue_en),
		.src_ready(src_ready),
		.prf_value(prf_value),
		.exec_valid(exec_valid),
		.exec_info(exec_info)
	);

	adder_exec u_exec (
		.CLK(CLK),
		.rst_n(rst_n),
		.exec_valid(exec_valid),
		.exec_info(exec_info),
		.result(result)
	);

	phy_regfile u_prf (
		.CLK(CLK),
		.rst_n(rst_n),
		.wb(result),
		.alloc_valid(dispatch_fire),
		.alloc_rd(dispatch_info.rd),
		.preload(preload),
		.value(prf_value),
		.ready(src_ready)
	);

	issue_csr u_csr (
		.CLK(CLK),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.issue_fire(exec_valid),
		.prf_value(prf_value),
		.issue_en(issue_en),
		.preload(preload)
	);

endmodule

/* tests/adder_issue_chk.sv */
// bound into adder_issue_top; reaches u_issue.buf_full by hierarchical name, so the instance name is fixed
`timescale 1ns/10ps

module adder_issue_chk (
	input logic clk,
	input logic rst_n,
	input logic wb_ack,
	input logic result_valid,
	input logic issue_en,
	input logic exec_valid,
	input logic queue_full,
	input logic dispatch_ready
);

	logic issued_once;
	int fail_cnt = 0;

	// any issue so far, results may trail a disable
	always_ff @(posedge clk) begin
		if (!rst_n)
			issued_once <= 1'b0;
		else if (exec_valid)
			issued_once <= 1'b1;
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			fail_cnt++;
			$error("wb_ack stayed high for two cycles");
		end

	no_result_disabled: assert property (@(posedge clk) disable iff (!rst_n)
		(!issue_en && !issued_once) |-> !result_valid)
		else begin
			fail_cnt++;
			$error("result appeared while issue was disabled");
		end

	full_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
		(queue_full && !exec_valid) |-> !dispatch_ready)
		else begin
			fail_cnt++;
			$error("dispatch_ready high with a full queue and no issue");
		end

endmodule

bind adder_issue_top adder_issue_chk u_chk (
	.clk(CLK),
	.rst_n(rst_n),
	.wb_ack(wb_ack),
	.result_valid(result.valid),
	.issue_en(issue_en),
	.exec_valid(exec_valid),
	.queue_full(u_issue.buf_full),
	.dispatch_ready(dispatch_ready)
);

/* tests/adder_issue_tb.sv */
// table driven test of adder_issue_top; expects ISSUE_DEPTH below 8 and PREG_NUM of at least 31
`timescale 1ns/10ps
`include "adder_issue_macros.svh"

module adder_issue_tb;

	localparam int nrows = 44;
	localparam int cycle_limit = nrows * 8 + 200;
	localparam logic [`WB_ADR_W-1:0] adr_ctrl = `WB_ADR_W'h00;
	localparam logic [`WB_ADR_W-1:0] adr_issued = `WB_ADR_W'h04;
	localparam logic [`WB_ADR_W-1:0] adr_prf_sel = `WB_ADR_W'h08;
	localparam logic [`WB_ADR_W-1:0] adr_prf_lo = `WB_ADR_W'h0c;
	localparam logic [`WB_ADR_W-1:0] adr_prf_hi = `WB_ADR_W'h10;

	logic clk;
	logic rst_n;
	logic dispatch_valid;
	logic dispatch_ready;
	issue_pkg::issue_info_t dispatch_info;
	issue_pkg::wb_result_t result;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`WB_ADR_W-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	issue_pkg::issue_info_t rows [nrows];
	issue_pkg::xlen_t expv [nrows];
	issue_pkg::xlen_t model_reg [`PREG_NUM];
	issue_pkg::xlen_t pre_fixed [6];
	issue_pkg::xlen_t pre_rand [6];
	issue_pkg::xlen_t got_val [`PREG_NUM];
	int got_cnt [`PREG_NUM];
	int got_cyc [`PREG_NUM];
	int row_n;
	int errors;
	int checks;
	int res_count;
	int cycle;
	logic [31:0] rng;

	adder_issue_top DUT (
		.CLK(clk),
		.rst_n(rst_n),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready),
		.dispatch_info(dispatch_info),
		.result(result),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// result monitor and run limit
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (rst_n && result.valid) begin
			got_val[result.rd] = result.data;
			got_cnt[result.rd] = got_cnt[result.rd] + 1;
			got_cyc[result.rd] = cycle;
			res_count = res_count + 1;
		end
		if (cycle >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// operand rule applied to the shadow registers
	function automatic issue_pkg::xlen_t model_result(input issue_pkg::issue_info_t r);
		issue_pkg::xlen_t a;
		issue_pkg::xlen_t b;
		issue_pkg::xlen_t s;
		a = model_reg[r.rs1];
		b = r.imm;
		case (r.op)
			issue_pkg::op_lui: a = '0;
			issue_pkg::op_auipc: a = r.pc;
			issue_pkg::op_addi, issue_pkg::op_addiw: b = r.imm;
			default: b = model_reg[r.rs2];
		endcase
		if (r.op == issue_pkg::op_sub || r.op == issue_pkg::op_subw)
			s = a - b;
		else
			s = a + b;
		if (r.op == issue_pkg::op_addiw || r.op == issue_pkg::op_addw ||
		    r.op == issue_pkg::op_subw)
			s = {{32{s[31]}}, s[31:0]};
		return s;
	endfunction

	task automatic add_row(input issue_pkg::adder_op_e op, input issue_pkg::preg_idx_t rd,
	                       rs1, rs2, input issue_pkg::xlen_t imm, pc);
		rows[row_n] = '{op: op, pc: pc, imm: imm, rd: rd, rs1: rs1, rs2: rs2};
		expv[row_n] = model_result(rows[row_n]);
		if (rd != '0)
			model_reg[rd] = expv[row_n];
		row_n++;
	endtask

	function automatic int count_writes(input int first, input int last);
		int n;
		n = 0;
		for (int i = first; i <= last; i++)
			if (rows[i].rd != '0)
				n++;
		return n;
	endfunction

	task automatic write_reg(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		@(posedge clk);
		while (!wb_ack)
			@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic read_reg(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		@(posedge clk);
		while (!wb_ack)
			@(posedge clk);
		data = wb_dat_r;
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic load_preg(input int idx, input issue_pkg::xlen_t v);
		write_reg(adr_prf_sel, 32'(idx));
		write_reg(adr_prf_hi, v[63:32]);
		write_reg(adr_prf_lo, v[31:0]);
	endtask

	task automatic send_row(input int i);
		dispatch_info = rows[i];
		dispatch_valid = 1'b1;
		@(posedge clk);
		while (!dispatch_ready)
			@(posedge clk);
		#1 dispatch_valid = 1'b0;
	endtask

	task automatic clear_results();
		for (int r = 0; r < `PREG_NUM; r++) begin
			got_cnt[r] = 0;
			got_cyc[r] = 0;
		end
		res_count = 0;
	endtask

	// a few idle cycles afterwards expose duplicate results
	task automatic wait_results(input int n);
		while (res_count < n) begin
			@(posedge clk);
			#1;
		end
		repeat (4) @(posedge clk);
		#1;
	endtask

	task automatic check_rows(input int first, input int last);
		int n;
		n = count_writes(first, last);
		checks++;
		assert (res_count == n) else begin
			errors++;
			$display("ERROR %0t: %0d results, expected %0d", $time, res_count, n);
		end
		for (int i = first; i <= last; i++) begin
			if (rows[i].rd != '0) begin
				checks++;
				assert (got_cnt[rows[i].rd] == 1 && got_val[rows[i].rd] == expv[i]) else begin
					errors++;
					$display("ERROR %0t: row %0d rd %0d got %h x%0d, expected %h", $time, i,
					         rows[i].rd, got_val[rows[i].rd], got_cnt[rows[i].rd], expv[i]);
				end
			end
		end
	endtask

	initial begin
		logic [31:0] lo;
		logic [31:0] hi;
		issue_pkg::preg_idx_t rd;
		dispatch_valid = 1'b0;
		dispatch_info = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		rst_n = 1'b0;
		rng = 32'h3724_239f;
		row_n = 0;
		errors = 0;
		checks = 0;
		cycle = 0;
		clear_results();
		for (int r = 0; r < `PREG_NUM; r++)
			model_reg[r] = '0;

		pre_fixed = '{64'h0000_0000_7fff_ffff, 64'h1, 64'hffff_ffff_ffff_fff0,
		              64'h1234_5678_9abc_def0, 64'd100, 64'h0000_0001_0000_0005};
		for (int r = 1; r <= 6; r++)
			model_reg[r] = pre_fixed[r-1];
		// one row per op, then a RAW chain from r14
		add_row(issue_pkg::op_lui, 5'd7, 5'd0, 5'd0, 64'hffff_ffff_8000_0000, 64'h0);
		add_row(issue_pkg::op_auipc, 5'd8, 5'd0, 5'd0, 64'h1_2000, 64'h8000_1000);
		add_row(issue_pkg::op_addi, 5'd9, 5'd3, 5'd0, 64'hffff_ffff_ffff_fffb, 64'h0);
		add_row(issue_pkg::op_addiw, 5'd10, 5'd1, 5'd0, 64'h1, 64'h0);
		add_row(issue_pkg::op_add, 5'd11, 5'd4, 5'd6, 64'h0, 64'h0);
		add_row(issue_pkg::op_addw, 5'd12, 5'd6, 5'd1, 64'h0, 64'h0);
		add_row(issue_pkg::op_sub, 5'd13, 5'd2, 5'd5, 64'h0, 64'h0);
		add_row(issue_pkg::op_subw, 5'd14, 5'd2, 5'd6, 64'h0, 64'h0);
		add_row(issue_pkg::op_addi, 5'd15, 5'd14, 5'd0, 64'h3, 64'h0);
		add_row(issue_pkg::op_add, 5'd16, 5'd15, 5'd5, 64'h0, 64'h0);
		add_row(issue_pkg::op_subw, 5'd17, 5'd16, 5'd1, 64'h0, 64'h0);
		add_row(issue_pkg::op_addiw, 5'd18, 5'd17, 5'd0, 64'h7, 64'h0);

		// random rows read only r1..r6, every fourth row targets r0
		for (int r = 1; r <= 6; r++) begin
			rng = xorshift(rng);
			hi = rng;
			rng = xorshift(rng);
			pre_rand[r-1] = {hi, rng};
			model_reg[r] = pre_rand[r-1];
		end
		for (int i = 0; i < 32; i++) begin
			rd = (i % 4 == 3) ? 5'd0 : issue_pkg::preg_idx_t'(7 + i - i / 4);
			rng = xorshift(rng);
			lo = rng;
			rng = xorshift(rng);
			hi = rng;
			rng = xorshift(rng);
			add_row(issue_pkg::adder_op_e'(rng[2:0]), rd,
			        issue_pkg::preg_idx_t'(lo % 6 + 1), issue_pkg::preg_idx_t'(hi % 6 + 1),
			        {{32{lo[31]}}, lo}, {hi, rng});
		end

		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		read_reg(adr_ctrl, lo);
		checks++;
		assert (lo == 32'd0) else begin
			errors++;
			$display("ERROR %0t: CTRL after reset is %h", $time, lo);
		end
		for (int r = 1; r <= 6; r++)
			load_preg(r, pre_fixed[r-1]);
		for (int r = 1; r <= 6; r++) begin
			write_reg(adr_prf_sel, 32'(r));
			read_reg(adr_prf_lo, lo);
			read_reg(adr_prf_hi, hi);
			checks++;
			assert ({hi, lo} == pre_fixed[r-1]) else begin
				errors++;
				$display("ERROR %0t: r%0d reads %h, expected %h", $time, r, {hi, lo},
				         pre_fixed[r-1]);
			end
		end

		// issue disabled, fill the queue and hold one more row
		clear_results();
		for (int i = 0; i < `ISSUE_DEPTH; i++)
			send_row(i);
		dispatch_info = rows[`ISSUE_DEPTH];
		dispatch_valid = 1'b1;
		repeat (8) begin
			@(posedge clk);
			checks++;
			assert (!dispatch_ready) else begin
				errors++;
				$display("ERROR %0t: dispatch_ready high with a full queue", $time);
			end
		end
		#1 dispatch_valid = 1'b0;
		checks++;
		assert (res_count == 0) else begin
			errors++;
			$display("ERROR %0t: %0d results while issue was disabled", $time, res_count);
		end

		write_reg(adr_ctrl, 32'd1);
		for (int i = `ISSUE_DEPTH; i < 8; i++)
			send_row(i);
		wait_results(count_writes(0, 7));
		check_rows(0, 7);

		// no bypass, so a consumer result trails its producer by two cycles or more
		clear_results();
		for (int i = 8; i < 12; i++)
			send_row(i);
		wait_results(count_writes(8, 11));
		check_rows(8, 11);
		for (int i = 9; i < 12; i++) begin
			checks++;
			assert (got_cyc[rows[i].rd] >= got_cyc[rows[i-1].rd] + 2) else begin
				errors++;
				$display("ERROR %0t: row %0d result less than two cycles after its producer",
				         $time, i);
			end
		end

		clear_results();
		for (int r = 1; r <= 6; r++)
			load_preg(r, pre_rand[r-1]);
		for (int i = 12; i < nrows; i++)
			send_row(i);
		wait_results(count_writes(12, nrows - 1));
		check_rows(12, nrows - 1);
		read_reg(adr_issued, lo);
		checks++;
		assert (lo == 32'(nrows)) else begin
			errors++;
			$display("ERROR %0t: ISSUED is %0d, expected %0d", $time, lo, nrows);
		end

		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
		         DUT.u_chk.fail_cnt);
		if (errors == 0 && DUT.u_chk.fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* adder_issue_top.f */
+incdir+common
common/issue_pkg.sv
adder_issue/issue_buffer.sv
adder_issue/lzc.sv
adder_issue/adder_issue.sv
adder_issue/adder_exec.sv
hw/phy_regfile.sv
hw/issue_csr.sv
hw/adder_issue_top.sv
tests/adder_issue_chk.sv
tests/adder_issue_tb.sv
